/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 4;
  localparam int NREG   = 16;

  // base opcodes handled by this pipeline
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one fetched word seen through every base format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

`default_nettype wire

/* hdl/issue_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded instruction handed from decode to execute under ex_load
interface issue_if;
  import rv_pkg::*;

  logic [XLEN-1:0]   op1;
  logic [XLEN-1:0]   op2;
  alu_op_e           alu_op;
  logic [REG_AW-1:0] rd;
  logic              rd_wen;
  logic              is_branch;
  logic              is_jump;
  logic [2:0]        funct3;
  logic [XLEN-1:0]   target;
  logic [XLEN-1:0]   pc;
  logic              illegal;

  modport decoder (
    output op1, op2, alu_op, rd, rd_wen, is_branch, is_jump, funct3, target, pc, illegal
  );

  modport exec (
    input op1, op2, alu_op, rd, rd_wen, is_branch, is_jump, funct3, target, pc, illegal
  );

endinterface

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic [rv_pkg::REG_AW-1:0] raddr1_i,
  input  wire logic [rv_pkg::REG_AW-1:0] raddr2_i,
  output logic      [rv_pkg::XLEN-1:0]   rdata1_o,
  output logic      [rv_pkg::XLEN-1:0]   rdata2_o,
  input  wire logic                      we_i,
  input  wire logic [rv_pkg::REG_AW-1:0] waddr_i,
  input  wire logic [rv_pkg::XLEN-1:0]   wdata_i
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [NREG];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < NREG; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero and there is no bypass from the write port
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* hdl/busy_table.sv */
`timescale 1ns/1ps
`default_nettype none

module busy_table (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      inc_i,
  input  wire logic [rv_pkg::REG_AW-1:0] inc_rd_i,
  input  wire logic                      dec_i,
  input  wire logic [rv_pkg::REG_AW-1:0] dec_rd_i,
  input  wire logic [rv_pkg::REG_AW-1:0] src1_i,
  input  wire logic [rv_pkg::REG_AW-1:0] src2_i,
  output logic                           src1_busy_o,
  output logic                           src2_busy_o
);
  import rv_pkg::*;

  // outstanding writes in execute and writeback
  logic [1:0] cnt [NREG];

  assign cnt[0] = 2'd0;

  for (genvar g = 1; g < NREG; g++) begin : g_cnt
    logic inc_hit;
    logic dec_hit;

    assign inc_hit = inc_i && (inc_rd_i == REG_AW'(g));
    assign dec_hit = dec_i && (dec_rd_i == REG_AW'(g));

    always_ff @(posedge clk) begin
      if (rst) begin
        cnt[g] <= 2'd0;
      end else if (inc_hit && !dec_hit) begin
        cnt[g] <= cnt[g] + 2'd1;
      end else if (dec_hit && !inc_hit) begin
        cnt[g] <= cnt[g] - 2'd1;
      end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      (inc_hit && !dec_hit) |-> (cnt[g] != 2'd3))
      else $error("busy counter overflow on x%0d", g);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      dec_hit |-> (cnt[g] != 2'd0))
      else $error("busy counter decrement from zero on x%0d", g);
  end

  assign src1_busy_o = (cnt[src1_i] != 2'd0);
  assign src2_busy_o = (cnt[src2_i] != 2'd0);

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      id_load_i,
  input  wire logic [rv_pkg::XLEN-1:0]   inst_i,
  input  wire logic [rv_pkg::XLEN-1:0]   pc_i,
  input  wire logic                      src1_busy_i,
  input  wire logic                      src2_busy_i,
  input  wire logic [rv_pkg::XLEN-1:0]   rdata1_i,
  input  wire logic [rv_pkg::XLEN-1:0]   rdata2_i,
  input  wire logic                      ex_fwd_valid_i,
  input  wire logic [rv_pkg::REG_AW-1:0] ex_fwd_rd_i,
  input  wire logic [rv_pkg::XLEN-1:0]   ex_fwd_value_i,
  output logic      [rv_pkg::REG_AW-1:0] rs1_o,
  output logic      [rv_pkg::REG_AW-1:0] rs2_o,
  output logic                           hazard_o,
  issue_if.decoder                       issue
);
  import rv_pkg::*;

  inst_u           inst_q;
  logic [XLEN-1:0] pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      inst_q <= '0;
    end else if (id_load_i) begin
      inst_q <= inst_i;
    end
  end

  always_ff @(posedge clk) begin
    if (id_load_i) begin
      pc_q <= pc_i;
    end
  end

  // register fields lose their upper bit
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic              funct7_b5;
  logic              funct7_zero;
  logic [REG_AW-1:0] rd;

  assign opcode      = inst_q.r.opcode;
  assign funct3      = inst_q.i.funct3;
  assign funct7_b5   = inst_q.r.funct7[5];
  assign funct7_zero = ({inst_q.r.funct7[6], inst_q.r.funct7[4:0]} == 6'd0);
  assign rd          = inst_q.r.rd[REG_AW-1:0];
  assign rs1_o       = inst_q.s.rs1[REG_AW-1:0];
  assign rs2_o       = inst_q.s.rs2[REG_AW-1:0];

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign imm_i = {{20{inst_q.i.imm11_0[11]}}, inst_q.i.imm11_0};
  assign imm_b = {{19{inst_q.b.imm12}}, inst_q.b.imm12, inst_q.b.imm11,
                  inst_q.b.imm10_5, inst_q.b.imm4_1, 1'b0};
  assign imm_u = {inst_q.u.imm31_12, 12'd0};
  assign imm_j = {{11{inst_q.j.imm20}}, inst_q.j.imm20, inst_q.j.imm19_12,
                  inst_q.j.imm11, inst_q.j.imm10_1, 1'b0};

  // youngest result sits in execute
  logic            fwd1;
  logic            fwd2;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;

  assign fwd1 = ex_fwd_valid_i && (ex_fwd_rd_i == rs1_o);
  assign fwd2 = ex_fwd_valid_i && (ex_fwd_rd_i == rs2_o);
  assign src1 = fwd1 ? ex_fwd_value_i : rdata1_i;
  assign src2 = fwd2 ? ex_fwd_value_i : rdata2_i;

  logic use_rs1;
  logic use_rs2;
  logic illegal;

  always_comb begin
    issue.op1       = '0;
    issue.op2       = '0;
    issue.alu_op    = ALU_ADD;
    issue.rd_wen    = 1'b0;
    issue.is_branch = 1'b0;
    issue.is_jump   = 1'b0;
    issue.target    = '0;
    use_rs1         = 1'b0;
    use_rs2         = 1'b0;
    illegal         = 1'b0;
    case (opcode)
      OP_LUI: begin
        issue.op2    = imm_u;
        issue.rd_wen = 1'b1;
      end
      OP_AUIPC: begin
        issue.op1    = pc_q;
        issue.op2    = imm_u;
        issue.rd_wen = 1'b1;
      end
      OP_JAL: begin
        // link value pc+4 comes out of the adder
        issue.op1     = pc_q;
        issue.op2     = XLEN'(4);
        issue.rd_wen  = 1'b1;
        issue.is_jump = 1'b1;
        issue.target  = pc_q + imm_j;
      end
      OP_JALR: begin
        issue.op1     = pc_q;
        issue.op2     = XLEN'(4);
        issue.rd_wen  = 1'b1;
        issue.is_jump = 1'b1;
        issue.target  = (src1 + imm_i) & ~XLEN'(1);
        use_rs1       = 1'b1;
      end
      OP_BRANCH: begin
        issue.op1       = src1;
        issue.op2       = src2;
        issue.alu_op    = ALU_SUB;
        issue.is_branch = 1'b1;
        issue.target    = pc_q + imm_b;
        use_rs1         = 1'b1;
        use_rs2         = 1'b1;
        illegal         = (funct3[2:1] == 2'b01);
      end
      OP_IMM: begin
        issue.op1    = src1;
        issue.op2    = imm_i;
        // only the right shifts take funct7 bit 5
        issue.alu_op = alu_op_e'({(funct3 == 3'b101) && funct7_b5, funct3});
        issue.rd_wen = 1'b1;
        use_rs1      = 1'b1;
      end
      OP_REG: begin
        issue.op1    = src1;
        issue.op2    = src2;
        issue.alu_op = alu_op_e'({funct7_b5, funct3});
        issue.rd_wen = 1'b1;
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
        illegal      = !funct7_zero || (funct7_b5 && (funct3 != 3'b000) && (funct3 != 3'b101));
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      issue.rd_wen    = 1'b0;
      issue.is_branch = 1'b0;
    end
  end

  assign issue.rd      = rd;
  assign issue.funct3  = funct3;
  assign issue.pc      = pc_q;
  assign issue.illegal = illegal;

  // pending write that the execute forward cannot supply
  assign hazard_o = (use_rs1 && src1_busy_i && !fwd1) || (use_rs2 && src2_busy_i && !fwd2);

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      ex_load_i,
  input  wire logic                      wb_load_i,
  issue_if.exec                          issue,
  output logic                           ex_fwd_valid_o,
  output logic      [rv_pkg::REG_AW-1:0] ex_fwd_rd_o,
  output logic      [rv_pkg::XLEN-1:0]   ex_fwd_value_o,
  output logic      [rv_pkg::REG_AW-1:0] wb_rd_o,
  output logic                           wb_wen_o,
  output logic      [rv_pkg::XLEN-1:0]   wb_value_o,
  output logic                           wb_jump_o,
  output logic      [rv_pkg::XLEN-1:0]   wb_target_o,
  output logic      [rv_pkg::XLEN-1:0]   wb_pc_o,
  output logic                           wb_illegal_o
);
  import rv_pkg::*;

  logic [XLEN-1:0]   op1;
  logic [XLEN-1:0]   op2;
  alu_op_e           alu_op;
  logic [REG_AW-1:0] rd;
  logic              rd_wen;
  logic              is_branch;
  logic              is_jump;
  logic [2:0]        funct3;
  logic [XLEN-1:0]   target;
  logic [XLEN-1:0]   pc;
  logic              illegal;

  always_ff @(posedge clk) begin
    if (ex_load_i) begin
      op1       <= issue.op1;
      op2       <= issue.op2;
      alu_op    <= issue.alu_op;
      rd        <= issue.rd;
      is_branch <= issue.is_branch;
      is_jump   <= issue.is_jump;
      funct3    <= issue.funct3;
      target    <= issue.target;
      pc        <= issue.pc;
      illegal   <= issue.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_wen   <= 1'b0;
      wb_wen_o <= 1'b0;
    end else begin
      if (ex_load_i) begin
        rd_wen <= issue.rd_wen;
      end
      if (wb_load_i) begin
        wb_wen_o <= rd_wen && !illegal;
      end
    end
  end

  logic [XLEN-1:0] result;

  always_comb begin
    case (alu_op)
      ALU_ADD:  result = op1 + op2;
      ALU_SUB:  result = op1 - op2;
      ALU_SLL:  result = op1 << op2[4:0];
      ALU_SLT:  result = XLEN'($signed(op1) < $signed(op2));
      ALU_SLTU: result = XLEN'(op1 < op2);
      ALU_XOR:  result = op1 ^ op2;
      ALU_SRL:  result = op1 >> op2[4:0];
      ALU_SRA:  result = $unsigned($signed(op1) >>> op2[4:0]);
      ALU_OR:   result = op1 | op2;
      ALU_AND:  result = op1 & op2;
      default:  result = '0;
    endcase
  end

  // funct3[2:1] picks the compare and funct3[0] inverts it
  logic cmp;
  logic taken;

  always_comb begin
    case (funct3[2:1])
      2'b00:   cmp = (op1 == op2);
      2'b10:   cmp = ($signed(op1) < $signed(op2));
      2'b11:   cmp = (op1 < op2);
      default: cmp = 1'b0;
    endcase
  end

  assign taken = cmp ^ funct3[0];

  assign ex_fwd_valid_o = rd_wen && (rd != '0);
  assign ex_fwd_rd_o    = rd;
  assign ex_fwd_value_o = result;

  // retire record
  always_ff @(posedge clk) begin
    if (wb_load_i) begin
      wb_rd_o      <= rd;
      wb_value_o   <= result;
      wb_jump_o    <= is_jump || (is_branch && taken);
      wb_target_o  <= target;
      wb_pc_o      <= pc;
      wb_illegal_o <= illegal;
    end
  end

endmodule

`default_nettype wire

/* hdl/stage_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_ctrl (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic inst_valid_i,
  output logic      inst_ready_o,
  input  wire logic hazard_i,
  input  wire logic retire_ready_i,
  output logic      retire_valid_o,
  output logic      id_load_o,
  output logic      ex_load_o,
  output logic      wb_load_o,
  output logic      ex_valid_o
);

  logic id_valid;
  logic ex_valid;
  logic wb_valid;
  logic wb_free;
  logic ex_free;

  // back-pressure chain from retire back to the input
  assign wb_free      = !wb_valid || retire_ready_i;
  assign ex_free      = !ex_valid || wb_free;
  assign wb_load_o    = ex_valid && wb_free;
  assign ex_load_o    = id_valid && !hazard_i && ex_free;
  assign inst_ready_o = !id_valid || ex_load_o;
  assign id_load_o    = inst_valid_i && inst_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      if (id_load_o) begin
        id_valid <= 1'b1;
      end else if (ex_load_o) begin
        id_valid <= 1'b0;
      end
      if (ex_load_o) begin
        ex_valid <= 1'b1;
      end else if (wb_load_o) begin
        ex_valid <= 1'b0;
      end
      if (wb_load_o) begin
        wb_valid <= 1'b1;
      end else if (retire_ready_i) begin
        wb_valid <= 1'b0;
      end
    end
  end

  assign retire_valid_o = wb_valid;
  assign ex_valid_o     = ex_valid;

  a_retire_held: assert property (@(posedge clk) disable iff (rst)
    (retire_valid_o && !retire_ready_i) |=> retire_valid_o)
    else $error("retire_valid_o dropped without acceptance");

endmodule

`default_nettype wire

/* hdl/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_top (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      inst_valid_i,
  output logic                           inst_ready_o,
  input  wire logic [rv_pkg::XLEN-1:0]   inst_i,
  input  wire logic [rv_pkg::XLEN-1:0]   pc_i,
  output logic                           retire_valid_o,
  input  wire logic                      retire_ready_i,
  output logic      [rv_pkg::XLEN-1:0]   retire_pc_o,
  output logic      [rv_pkg::REG_AW-1:0] retire_rd_o,
  output logic                           retire_wen_o,
  output logic      [rv_pkg::XLEN-1:0]   retire_value_o,
  output logic                           retire_jump_o,
  output logic      [rv_pkg::XLEN-1:0]   retire_target_o,
  output logic                           retire_illegal_o
);
  import rv_pkg::*;

  logic              id_load;
  logic              ex_load;
  logic              wb_load;
  logic              ex_valid;
  logic              hazard;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [XLEN-1:0]   rdata1;
  logic [XLEN-1:0]   rdata2;
  logic              src1_busy;
  logic              src2_busy;
  logic              fwd_wen;
  logic              fwd_valid;
  logic [REG_AW-1:0] fwd_rd;
  logic [XLEN-1:0]   fwd_value;
  logic              retire_write;

  issue_if issue_bus ();

  // forward only while execute holds an instruction
  assign fwd_valid    = ex_valid && fwd_wen;
  assign retire_write = retire_valid_o && retire_ready_i && retire_wen_o;

  stage_ctrl stage_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .inst_valid_i  (inst_valid_i),
    .inst_ready_o  (inst_ready_o),
    .hazard_i      (hazard),
    .retire_ready_i(retire_ready_i),
    .retire_valid_o(retire_valid_o),
    .id_load_o     (id_load),
    .ex_load_o     (ex_load),
    .wb_load_o     (wb_load),
    .ex_valid_o    (ex_valid)
  );

  inst_decoder inst_decoder_inst (
    .clk           (clk),
    .rst           (rst),
    .id_load_i     (id_load),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .src1_busy_i   (src1_busy),
    .src2_busy_i   (src2_busy),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .ex_fwd_valid_i(fwd_valid),
    .ex_fwd_rd_i   (fwd_rd),
    .ex_fwd_value_i(fwd_value),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .hazard_o      (hazard),
    .issue         (issue_bus.decoder)
  );

  reg_file reg_file_inst (
    .clk     (clk),
    .rst     (rst),
    .raddr1_i(rs1),
    .raddr2_i(rs2),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2),
    .we_i    (retire_write),
    .waddr_i (retire_rd_o),
    .wdata_i (retire_value_o)
  );

  busy_table busy_table_inst (
    .clk        (clk),
    .rst        (rst),
    .inc_i      (ex_load && issue_bus.rd_wen),
    .inc_rd_i   (issue_bus.rd),
    .dec_i      (retire_write),
    .dec_rd_i   (retire_rd_o),
    .src1_i     (rs1),
    .src2_i     (rs2),
    .src1_busy_o(src1_busy),
    .src2_busy_o(src2_busy)
  );

  exec_unit exec_unit_inst (
    .clk           (clk),
    .rst           (rst),
    .ex_load_i     (ex_load),
    .wb_load_i     (wb_load),
    .issue         (issue_bus.exec),
    .ex_fwd_valid_o(fwd_wen),
    .ex_fwd_rd_o   (fwd_rd),
    .ex_fwd_value_o(fwd_value),
    .wb_rd_o       (retire_rd_o),
    .wb_wen_o      (retire_wen_o),
    .wb_value_o    (retire_value_o),
    .wb_jump_o     (retire_jump_o),
    .wb_target_o   (retire_target_o),
    .wb_pc_o       (retire_pc_o),
    .wb_illegal_o  (retire_illegal_o)
  );

endmodule

`default_nettype wire

/* dv/tb_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;
  import rv_pkg::*;

  localparam int          MAX_VEC     = 64;
  localparam int          TIMEOUT_CYC = 200;
  localparam int unsigned RAND_SEED   = 32'h02ad_3eb6;

  logic              clk;
  logic              rst;
  logic              inst_valid_i;
  logic              inst_ready_o;
  logic [XLEN-1:0]   inst_i;
  logic [XLEN-1:0]   pc_i;
  logic              retire_valid_o;
  logic              retire_ready_i;
  logic [XLEN-1:0]   retire_pc_o;
  logic [REG_AW-1:0] retire_rd_o;
  logic              retire_wen_o;
  logic [XLEN-1:0]   retire_value_o;
  logic              retire_jump_o;
  logic [XLEN-1:0]   retire_target_o;
  logic              retire_illegal_o;

  // one row per instruction in program order
  logic [31:0] vec_pc      [MAX_VEC];
  logic [31:0] vec_inst    [MAX_VEC];
  logic [31:0] exp_rd      [MAX_VEC];
  logic [31:0] exp_wen     [MAX_VEC];
  logic [31:0] exp_value   [MAX_VEC];
  logic [31:0] exp_jump    [MAX_VEC];
  logic [31:0] exp_target  [MAX_VEC];
  logic [31:0] exp_illegal [MAX_VEC];

  int          num_vec;
  int          check_count;
  int          error_count;
  int          timeout_count;
  logic        abort;

  decode_top decode_top_inst (
    .clk             (clk),
    .rst             (rst),
    .inst_valid_i    (inst_valid_i),
    .inst_ready_o    (inst_ready_o),
    .inst_i          (inst_i),
    .pc_i            (pc_i),
    .retire_valid_o  (retire_valid_o),
    .retire_ready_i  (retire_ready_i),
    .retire_pc_o     (retire_pc_o),
    .retire_rd_o     (retire_rd_o),
    .retire_wen_o    (retire_wen_o),
    .retire_value_o  (retire_value_o),
    .retire_jump_o   (retire_jump_o),
    .retire_target_o (retire_target_o),
    .retire_illegal_o(retire_illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          got;
    int          fields;
    string       line;
    logic [31:0] pc_v;
    logic [31:0] inst_v;
    logic [31:0] rd_v;
    logic [31:0] wen_v;
    logic [31:0] val_v;
    logic [31:0] jmp_v;
    logic [31:0] tgt_v;
    logic [31:0] ill_v;
    num_vec = 0;
    fd = $fopen("dv/decode_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/decode_testdata.txt");
      error_count++;
    end else begin
      while (!$feof(fd) && (num_vec < MAX_VEC)) begin
        got = $fgets(line, fd);
        if (got > 0) begin
          // comment lines fail the scan and are skipped
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                           pc_v, inst_v, rd_v, wen_v, val_v, jmp_v, tgt_v, ill_v);
          if (fields == 8) begin
            vec_pc[num_vec]      = pc_v;
            vec_inst[num_vec]    = inst_v;
            exp_rd[num_vec]      = rd_v;
            exp_wen[num_vec]     = wen_v;
            exp_value[num_vec]   = val_v;
            exp_jump[num_vec]    = jmp_v;
            exp_target[num_vec]  = tgt_v;
            exp_illegal[num_vec] = ill_v;
            num_vec++;
          end
        end
      end
      $fclose(fd);
      if (num_vec == 0) begin
        $display("the data file holds no instructions");
        error_count++;
      end
    end
  endtask

  // returns on the rising edge where the instruction was taken
  task automatic wait_accept();
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    while (!taken && !abort && (waited < TIMEOUT_CYC)) begin
      @(negedge clk);
      taken = inst_ready_o;
      @(posedge clk);
      waited++;
    end
    if (!taken && !abort) begin
      $display("timeout at %0t: inst_ready_o stayed low for %0d cycles", $time, TIMEOUT_CYC);
      timeout_count++;
      abort = 1'b1;
    end
  endtask

  task automatic drive_inputs();
    int idx;
    int gap;
    idx = 0;
    @(posedge clk);
    while ((idx < num_vec) && !abort) begin
      gap = 0;
      if ($urandom_range(0, 3) == 0) begin
        gap = int'($urandom_range(1, 3));
      end
      if (gap > 0) begin
        inst_valid_i <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      inst_valid_i <= 1'b1;
      inst_i       <= vec_inst[idx];
      pc_i         <= vec_pc[idx];
      wait_accept();
      idx++;
    end
    inst_valid_i <= 1'b0;
  endtask

  task automatic check_retire(int idx);
    check_value("retire_pc_o", retire_pc_o, vec_pc[idx]);
    check_value("retire_wen_o", 32'(retire_wen_o), exp_wen[idx]);
    check_value("retire_illegal_o", 32'(retire_illegal_o), exp_illegal[idx]);
    check_value("retire_jump_o", 32'(retire_jump_o), exp_jump[idx]);
    // rd and value only matter for a register write
    if (exp_wen[idx] != 0) begin
      check_value("retire_rd_o", 32'(retire_rd_o), exp_rd[idx]);
      check_value("retire_value_o", retire_value_o, exp_value[idx]);
    end
    if ((exp_jump[idx] != 0) || (vec_inst[idx][6:0] == OP_BRANCH)) begin
      check_value("retire_target_o", retire_target_o, exp_target[idx]);
    end
  endtask

  task automatic watch_retire();
    int retired;
    int idle;
    retired = 0;
    idle    = 0;
    while ((retired < num_vec) && !abort) begin
      @(posedge clk);
      retire_ready_i <= ($urandom_range(0, 3) != 0);
      @(negedge clk);
      if (retire_valid_o && retire_ready_i) begin
        check_retire(retired);
        retired++;
        idle = 0;
      end else if (idle >= TIMEOUT_CYC) begin
        $display("timeout at %0t: no retire for %0d cycles, %0d of %0d retired",
                 $time, TIMEOUT_CYC, retired, num_vec);
        timeout_count++;
        abort = 1'b1;
      end else begin
        idle++;
      end
    end
    @(posedge clk);
    retire_ready_i <= 1'b0;
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    check_count    = 0;
    error_count    = 0;
    timeout_count  = 0;
    abort          = 1'b0;
    rst            = 1'b1;
    inst_valid_i   = 1'b0;
    inst_i         = '0;
    pc_i           = '0;
    retire_ready_i = 1'b0;

    load_vectors();

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // idle state right after reset
    @(negedge clk);
    check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
    check_value("inst_ready_o", 32'(inst_ready_o), 32'd1);

    if (num_vec > 0) begin
      fork
        drive_inputs();
        watch_retire();
      join
    end

    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hdl/rv_pkg.sv
hdl/issue_if.sv
hdl/reg_file.sv
hdl/busy_table.sv
hdl/inst_decoder.sv
hdl/exec_unit.sv
hdl/stage_ctrl.sv
hdl/decode_top.sv
dv/tb_decode_top.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_decode_top \
  -f project.f \
  -o tb_decode_top

sim_status=0
./obj_dir/tb_decode_top > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed (exit status $sim_status)"
  exit 1
fi

/* dv/decode_testdata.txt */
# columns (hex): pc inst rd wen value jump target illegal
# value is checked only when wen is set, target only for jumps and branches
00000100 00500093 1 1 00000005 0 00000000 0
00000104 FFD00113 2 1 FFFFFFFD 0 00000000 0
00000108 002081B3 3 1 00000002 0 00000000 0
0000010C 40208233 4 1 00000008 0 00000000 0
00000110 401102B3 5 1 FFFFFFF8 0 00000000 0
00000114 4012D333 6 1 FFFFFFFF 0 00000000 0
00000118 0012D3B3 7 1 07FFFFFF 0 00000000 0
0000011C 40115413 8 1 FFFFFFFE 0 00000000 0
00000120 00415493 9 1 0FFFFFFF 0 00000000 0
00000124 00309513 A 1 00000028 0 00000000 0
00000128 001125B3 B 1 00000001 0 00000000 0
0000012C 00113633 C 1 00000000 0 00000000 0
00000130 FFE12693 D 1 00000001 0 00000000 0
00000134 FFF0B713 E 1 00000001 0 00000000 0
00000138 0020C7B3 F 1 FFFFFFF8 0 00000000 0
0000013C 0020E1B3 3 1 FFFFFFFD 0 00000000 0
00000140 0020F233 4 1 00000005 0 00000000 0
00000144 0F017293 5 1 000000F0 0 00000000 0
00000148 1000E313 6 1 00000105 0 00000000 0
0000014C FFF0C393 7 1 FFFFFFFA 0 00000000 0
00000150 07B00013 0 1 0000007B 0 00000000 0
00000154 00000433 8 1 00000000 0 00000000 0
00000158 123454B7 9 1 12345000 0 00000000 0
0000015C 00001517 A 1 0000115C 0 00000000 0
00000160 FFFFF597 B 1 FFFFF160 0 00000000 0
00000164 010000EF 1 1 00000168 1 00000174 0
00000168 FF9FF16F 2 1 0000016C 1 00000160 0
0000016C 006201E7 3 1 00000170 1 0000000A 0
00000170 00E68463 0 0 00000000 1 00000178 0
00000174 00E69463 0 0 00000000 0 0000017C 0
00000178 0043C463 0 0 00000000 1 00000180 0
0000017C 0043D463 0 0 00000000 0 00000184 0
00000180 0043E463 0 0 00000000 0 00000188 0
00000184 0043F463 0 0 00000000 1 0000018C 0
00000188 FE0008E3 0 0 00000000 1 00000178 0
0000018C 0000A283 0 0 00000000 0 00000000 1
00000190 00128293 5 1 000000F1 0 00000000 0
00000194 00128293 5 1 000000F2 0 00000000 0
00000198 00528333 6 1 000001E4 0 00000000 0
0000019C 405303B3 7 1 000000F2 0 00000000 0
000001A0 0063C433 8 1 00000116 0 00000000 0
000001A4 000404E7 9 1 000001A8 1 00000116 0
000001A8 00D09533 A 1 000002D0 0 00000000 0
